// File: Bender.yml
package:
  name: fp_multifmt_slice

sources:
  - include_dirs:
      - source
    files:
      - source/fpslice_pkg.sv
      - source/lane_pipe.sv
      - source/slice_lane_op.sv
      - source/slice_result_pack.sv
      - source/fp_multifmt_slice.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/tb_fp_multifmt_slice.sv

// File: dv/tb_fp_multifmt_slice.sv
`timescale 1ns/1ps
`include "fpslice_consts.svh"

module tb_fp_multifmt_slice;

  localparam int TimeoutCycles = 2000;  // Whole run needs a few hundred cycles

  logic                      clk_i = 1'b0;
  logic                      rst_n_i;
  logic [`FPS_WIDTH-1:0]     op_a_i;
  logic [`FPS_WIDTH-1:0]     op_b_i;
  fpslice_pkg::op_e          op_i;
  fpslice_pkg::fp_fmt_e      fmt_i;
  logic                      vectorial_i;
  logic [`FPS_TAG_W-1:0]     tag_i;
  logic [`FPS_NUM_LANES-1:0] simd_mask_i;
  logic                      in_valid_i;
  logic                      in_ready_o;
  logic                      flush_i;
  logic [`FPS_WIDTH-1:0]     result_o;
  fpslice_pkg::status_t      status_o;
  logic [`FPS_TAG_W-1:0]     tag_o;
  logic                      out_valid_o;
  logic                      out_ready_i;
  logic                      busy_o;

  int                        cycle_cnt = 0;
  logic [31:0]               rng_state = 32'd38;
  logic [`FPS_WIDTH-1:0]     exp_res_q [$];  // Expected responses in request order
  fpslice_pkg::status_t      exp_st_q  [$];
  logic [`FPS_TAG_W-1:0]     exp_tag_q [$];
  int                        acc_cyc_q [$];  // Cycle of each acceptance

  fp_multifmt_slice dut_i (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .op_a_i      ( op_a_i      ),
    .op_b_i      ( op_b_i      ),
    .op_i        ( op_i        ),
    .fmt_i       ( fmt_i       ),
    .vectorial_i ( vectorial_i ),
    .tag_i       ( tag_i       ),
    .simd_mask_i ( simd_mask_i ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .flush_i     ( flush_i     ),
    .result_o    ( result_o    ),
    .status_o    ( status_o    ),
    .tag_o       ( tag_o       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

  always #20 clk_i = ~clk_i;  // 40 ns period

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      abort_run("Timeout: the DUT stopped answering before all tests finished");
    end
  end

  // ------------------------------------------------------------
  // Reporting and checks
  // ------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at cycle %0d", cycle_cnt);
  endtask

  task automatic check_result(input string name, input logic [`FPS_WIDTH-1:0] got,
                              input logic [`FPS_WIDTH-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_status(input string name, input fpslice_pkg::status_t got,
                              input fpslice_pkg::status_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_tag(input string name, input logic [`FPS_TAG_W-1:0] got,
                           input logic [`FPS_TAG_W-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus and reference model
  // ------------------------------------------------------------
  function logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Upper halves of two steps, the low LCG bits repeat too quickly
  function logic [31:0] rand32();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};
  endfunction

  // One lane on a zero-extended FP32 or FP16 operand pair
  function automatic logic [31:0] lane_model(input logic [31:0] a, input logic [31:0] b,
                                             input fpslice_pkg::op_e op, input bit wide,
                                             output bit nv);
    int          sp;
    int          ew;
    int          mw;
    logic [31:0] qn;
    logic [31:0] ma;
    logic [31:0] mb;
    logic [31:0] expm;
    logic [31:0] manm;
    logic [31:0] qbit;
    bit          na;
    bit          nb;
    logic        s;
    longint      ka;
    longint      kb;
    sp = wide ? 31 : 15;
    ew = wide ? 8 : 5;
    mw = wide ? 23 : 10;
    qn = wide ? `FPS_QNAN32 : {16'h0, `FPS_QNAN16};
    ma   = a & ((32'd1 << sp) - 1);
    mb   = b & ((32'd1 << sp) - 1);
    expm = ((32'd1 << ew) - 1) << mw;
    manm = (32'd1 << mw) - 1;
    qbit = 32'd1 << (mw - 1);
    na = ((ma & expm) == expm) && ((ma & manm) != 0);
    nb = ((mb & expm) == expm) && ((mb & manm) != 0);
    nv = 1'b0;
    if (op == fpslice_pkg::OP_MIN || op == fpslice_pkg::OP_MAX) begin
      nv = (na && (ma & qbit) == 0) || (nb && (mb & qbit) == 0);
      if (na && nb) return qn;
      if (na) return b;
      if (nb) return a;
      ka = a[sp] ? -longint'(ma) - 1 : longint'(ma);  // -0 maps below +0
      kb = b[sp] ? -longint'(mb) - 1 : longint'(mb);
      if (op == fpslice_pkg::OP_MIN) return (ka < kb) ? a : b;
      return (ka < kb) ? b : a;
    end
    case (op)
      fpslice_pkg::OP_SGNJN: s = ~b[sp];
      fpslice_pkg::OP_SGNJX: s = a[sp] ^ b[sp];
      default:               s = b[sp];
    endcase
    return ({31'b0, s} << sp) | ma;
  endfunction

  function automatic logic [31:0] slice_model(input logic [31:0] a, input logic [31:0] b,
                                              input fpslice_pkg::op_e op,
                                              input fpslice_pkg::fp_fmt_e fmt,
                                              input logic vec, input logic [1:0] mask,
                                              output fpslice_pkg::status_t st);
    logic [31:0] a0;
    logic [31:0] b0;
    logic [31:0] r0;
    logic [31:0] r1;
    bit          nv0;
    bit          nv1;
    st = '0;
    if (fmt == fpslice_pkg::FMT_FP32) begin
      r0 = lane_model(a, b, op, 1'b1, nv0);
      st.nv = nv0 & mask[0];
      return r0;
    end
    a0 = {16'h0, a[15:0]};
    b0 = {16'h0, b[15:0]};
    if (!vec && a[31:16] != 16'hffff) a0 = {16'h0, `FPS_QNAN16};  // Unboxed scalar
    if (!vec && b[31:16] != 16'hffff) b0 = {16'h0, `FPS_QNAN16};
    r0 = lane_model(a0, b0, op, 1'b0, nv0);
    if (!vec) begin
      st.nv = nv0 & mask[0];
      return {16'hffff, r0[15:0]};
    end
    r1 = lane_model({16'h0, a[31:16]}, {16'h0, b[31:16]}, op, 1'b0, nv1);
    st.nv = (nv0 & mask[0]) | (nv1 & mask[1]);
    return {r1[15:0], r0[15:0]};
  endfunction

  // Called at rising edge + 2 ns, returns there after acceptance
  task automatic drive_req(input logic [31:0] a, input logic [31:0] b,
                           input fpslice_pkg::op_e op, input fpslice_pkg::fp_fmt_e fmt,
                           input logic vec, input logic [3:0] tag, input logic [1:0] mask);
    fpslice_pkg::status_t st;
    logic [31:0]          res;
    res = slice_model(a, b, op, fmt, vec, mask, st);
    op_a_i      = a;
    op_b_i      = b;
    op_i        = op;
    fmt_i       = fmt;
    vectorial_i = vec;
    tag_i       = tag;
    simd_mask_i = mask;
    in_valid_i  = 1'b1;
    @(negedge clk_i);
    while (!in_ready_o) @(negedge clk_i);
    exp_res_q.push_back(res);
    exp_st_q.push_back(st);
    exp_tag_q.push_back(tag);
    acc_cyc_q.push_back(cycle_cnt);
    @(posedge clk_i);
    #2;
    in_valid_i = 1'b0;
  endtask

  task automatic take_result(input bit check_lat);
    int lat;
    @(negedge clk_i);
    while (!(out_valid_o && out_ready_i)) @(negedge clk_i);
    if (exp_res_q.size() == 0) begin
      abort_run("A result came out with no request pending");
    end
    check_result("result_o", result_o, exp_res_q.pop_front());
    check_status("status_o", status_o, exp_st_q.pop_front());
    check_tag("tag_o", tag_o, exp_tag_q.pop_front());
    lat = cycle_cnt - acc_cyc_q.pop_front();
    if (check_lat && lat != `FPS_PIPE_REGS) begin
      abort_run($sformatf("Result came %0d cycles after acceptance instead of %0d",
                          lat, `FPS_PIPE_REGS));
    end
    @(posedge clk_i);
    #2;
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic test_reset();
    repeat (16) begin
      @(negedge clk_i);
      check_flag("out_valid_o", out_valid_o, 1'b0);
      check_flag("busy_o", busy_o, 1'b0);
      check_flag("in_ready_o", in_ready_o, 1'b0);
    end
    @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_flag("out_valid_o", out_valid_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b0);
    @(negedge clk_i);
    check_flag("in_ready_o", in_ready_o, 1'b1);
    @(posedge clk_i);
    #2;
  endtask

  task automatic test_sign_inject();
    fpslice_pkg::op_e op;
    for (int i = 0; i < 12; i++) begin
      case (i % 3)
        0:       op = fpslice_pkg::OP_SGNJ;
        1:       op = fpslice_pkg::OP_SGNJN;
        default: op = fpslice_pkg::OP_SGNJX;
      endcase
      // Last one asks for a vectorial FP32 op, which runs as scalar
      drive_req(rand32(), rand32(), op, fpslice_pkg::FMT_FP32, i == 11, i[3:0], 2'b11);
      take_result(1'b1);
    end
  endtask

  task automatic test_fp16_minmax();
    logic [31:0]      dir_a [4];
    logic [31:0]      dir_b [4];
    logic [1:0]       mask;
    fpslice_pkg::op_e op;
    // sNaN sits in lane 0 only for the second case, in lane 1 only for the third
    dir_a = '{32'h3c00_7e00, 32'h3c00_c000, 32'h7e00_7e01, 32'h8000_0000};
    dir_b = '{32'h7e00_3c00, 32'hc000_7d00, 32'h7c01_fe00, 32'h0000_8000};
    for (int i = 0; i < 8; i++) begin
      op   = i[0] ? fpslice_pkg::OP_MAX : fpslice_pkg::OP_MIN;
      mask = lcg_next() >> 30;
      drive_req(rand32(), rand32(), op, fpslice_pkg::FMT_FP16, 1'b1, i[3:0], mask);
      take_result(1'b1);
    end
    // qNaN, sNaN, both NaN and signed zeros under each nonzero mask
    for (int c = 0; c < 4; c++) begin
      for (int k = 0; k < 6; k++) begin
        op = (k < 3) ? fpslice_pkg::OP_MIN : fpslice_pkg::OP_MAX;
        drive_req(dir_a[c], dir_b[c], op, fpslice_pkg::FMT_FP16, 1'b1, 4'(k),
                  2'((k % 3) + 1));
        take_result(1'b1);
      end
    end
  endtask

  task automatic test_scalar_boxing();
    drive_req(32'h1234_3c00, 32'hffff_c000, fpslice_pkg::OP_SGNJ, fpslice_pkg::FMT_FP16,
              1'b0, 4'h1, 2'b11);
    take_result(1'b1);
    drive_req(32'hffff_4400, 32'h0000_3c00, fpslice_pkg::OP_MIN, fpslice_pkg::FMT_FP16,
              1'b0, 4'h2, 2'b11);
    take_result(1'b1);
    // Leaves a flagged sNaN result with its mask bit set in lane 1's pipe
    drive_req(32'h7d00_3c00, 32'h3c00_4000, fpslice_pkg::OP_MIN, fpslice_pkg::FMT_FP16,
              1'b1, 4'h7, 2'b10);
    take_result(1'b1);
    // Lane 1 sees an sNaN pattern in the box bits
    drive_req(32'h7d00_3c00, 32'hffff_4000, fpslice_pkg::OP_MIN, fpslice_pkg::FMT_FP16,
              1'b0, 4'h3, 2'b11);
    take_result(1'b1);
    drive_req(32'hffff_7d00, 32'hffff_3c00, fpslice_pkg::OP_MAX, fpslice_pkg::FMT_FP16,
              1'b0, 4'h4, 2'b01);
    take_result(1'b1);
  endtask

  task automatic test_backpressure();
    logic [31:0] box;
    out_ready_i = 1'b0;
    fork
      begin
        // Two scalar items fill lane 0 while lane 1 stays empty
        for (int i = 0; i < 4; i++) begin
          box = (i < 2) ? 32'hffff_0000 : 32'h0;
          drive_req(rand32() | box, rand32() | box, fpslice_pkg::OP_MAX,
                    fpslice_pkg::FMT_FP16, i >= 2, 4'(8 + i), 2'b11);
        end
      end
      begin
        repeat (6) @(negedge clk_i);
        check_flag("in_ready_o", in_ready_o, 1'b0);  // Both stages hold an item
        check_flag("out_valid_o", out_valid_o, 1'b1);
        @(posedge clk_i);
        #2;
        out_ready_i = 1'b1;
        repeat (4) take_result(1'b0);
      end
    join
    @(negedge clk_i);
    if (exp_res_q.size() != 0) begin
      abort_run("Results were lost under back-pressure");
    end
    check_flag("out_valid_o", out_valid_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b0);
    @(posedge clk_i);
    #2;
  endtask

  task automatic test_flush();
    out_ready_i = 1'b0;
    drive_req(rand32(), rand32(), fpslice_pkg::OP_SGNJX, fpslice_pkg::FMT_FP32, 1'b0,
              4'h5, 2'b11);
    drive_req(rand32(), rand32(), fpslice_pkg::OP_MIN, fpslice_pkg::FMT_FP16, 1'b1,
              4'h6, 2'b11);
    flush_i = 1'b1;
    @(posedge clk_i);
    #2;
    flush_i = 1'b0;
    @(negedge clk_i);
    check_flag("out_valid_o", out_valid_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b0);
    exp_res_q.delete();  // Flushed items never come back
    exp_st_q.delete();
    exp_tag_q.delete();
    acc_cyc_q.delete();
    @(posedge clk_i);
    #2;
    out_ready_i = 1'b1;
    drive_req(rand32(), rand32(), fpslice_pkg::OP_SGNJN, fpslice_pkg::FMT_FP32, 1'b0,
              4'h9, 2'b11);
    take_result(1'b1);
  endtask

  initial begin
    rst_n_i     = 1'b0;
    op_a_i      = '0;
    op_b_i      = '0;
    op_i        = fpslice_pkg::OP_SGNJ;
    fmt_i       = fpslice_pkg::FMT_FP32;
    vectorial_i = 1'b0;
    tag_i       = '0;
    simd_mask_i = '0;
    in_valid_i  = 1'b0;
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    test_reset();
    test_sign_inject();
    test_fp16_minmax();
    test_scalar_boxing();
    test_backpressure();
    test_flush();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: source/fp_multifmt_slice.sv
`timescale 1ns/1ps
`include "fpslice_consts.svh"

module fp_multifmt_slice (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Request
  input  logic [`FPS_WIDTH-1:0]     op_a_i,
  input  logic [`FPS_WIDTH-1:0]     op_b_i,
  input  fpslice_pkg::op_e          op_i,
  input  fpslice_pkg::fp_fmt_e      fmt_i,
  input  logic                      vectorial_i,
  input  logic [`FPS_TAG_W-1:0]     tag_i,
  input  logic [`FPS_NUM_LANES-1:0] simd_mask_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  logic                      flush_i,
  // Response
  output logic [`FPS_WIDTH-1:0]     result_o,
  output fpslice_pkg::status_t      status_o,
  output logic [`FPS_TAG_W-1:0]     tag_o,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic                      busy_o
);

  logic                      vec_op;  // Only FP16 can be vectorial
  fpslice_pkg::slice_meta_t  meta_d;
  fpslice_pkg::slice_meta_t  meta_q;
  logic                      meta_valid;
  logic                      meta_busy;
  fpslice_pkg::lane_res_t    lane_res_d [`FPS_NUM_LANES];
  fpslice_pkg::lane_res_t    lane_res_q [`FPS_NUM_LANES];
  logic [`FPS_NUM_LANES-1:0] lane_in_valid;
  logic [`FPS_NUM_LANES-1:0] lane_in_ready;
  logic [`FPS_NUM_LANES-1:0] lane_out_valid;
  logic [`FPS_NUM_LANES-1:0] lane_out_ready;
  logic [`FPS_NUM_LANES-1:0] lane_busy;

  // ------------------------------------------------------------
  // Input side
  // ------------------------------------------------------------
  assign vec_op = vectorial_i && (fmt_i == fpslice_pkg::FMT_FP16);

  assign meta_d.tag       = tag_i;
  assign meta_d.fmt       = fmt_i;
  assign meta_d.vectorial = vec_op;

  assign in_ready_o = lane_in_ready[0];  // Lane 0 speaks for the slice

  // ------------------------------------------------------------
  // Lanes
  // ------------------------------------------------------------
  for (genvar lane = 0; lane < `FPS_NUM_LANES; lane++) begin : gen_lanes
    // Upper lanes only take vectorial items that lane 0 accepts
    assign lane_in_valid[lane]  = in_valid_i & ((lane == 0) | (vec_op & lane_in_ready[0]));
    assign lane_out_ready[lane] = out_ready_i & ((lane == 0) | meta_q.vectorial);

    slice_lane_op #(
      .EnableFp32 ( lane == 0 )
    ) i_lane_op (
      .op_a_i   ( op_a_i >> (lane * `FPS_FP16_W) ),
      .op_b_i   ( op_b_i >> (lane * `FPS_FP16_W) ),
      .op_i     ( op_i                           ),
      .fmt_i    ( fmt_i                          ),
      .scalar_i ( ~vec_op                        ),
      .mask_i   ( simd_mask_i[lane]              ),
      .res_o    ( lane_res_d[lane]               )
    );

    lane_pipe #(
      .payload_t ( fpslice_pkg::lane_res_t ),
      .NumRegs   ( `FPS_PIPE_REGS          )
    ) i_lane_pipe (
      .clk_i   ( clk_i                ),
      .rst_n_i ( rst_n_i              ),
      .flush_i ( flush_i              ),
      .data_i  ( lane_res_d[lane]     ),
      .valid_i ( lane_in_valid[lane]  ),
      .ready_o ( lane_in_ready[lane]  ),
      .data_o  ( lane_res_q[lane]     ),
      .valid_o ( lane_out_valid[lane] ),
      .ready_i ( lane_out_ready[lane] ),
      .busy_o  ( lane_busy[lane]      )
    );
  end

  // Tag, format and vectorial flag ride beside lane 0
  lane_pipe #(
    .payload_t ( fpslice_pkg::slice_meta_t ),
    .NumRegs   ( `FPS_PIPE_REGS            )
  ) i_meta_pipe (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .flush_i ( flush_i     ),
    .data_i  ( meta_d      ),
    .valid_i ( in_valid_i  ),
    .ready_o (             ),
    .data_o  ( meta_q      ),
    .valid_o ( meta_valid  ),
    .ready_i ( out_ready_i ),
    .busy_o  ( meta_busy   )
  );

  // ------------------------------------------------------------
  // Output side
  // ------------------------------------------------------------
  slice_result_pack i_result_pack (
    .lane0_i  ( lane_res_q[0] ),
    .lane1_i  ( lane_res_q[1] ),
    .meta_i   ( meta_q        ),
    .result_o ( result_o      ),
    .status_o ( status_o      )
  );

  assign tag_o       = meta_q.tag;
  assign out_valid_o = lane_out_valid[0] & meta_valid &
                       (~meta_q.vectorial | lane_out_valid[1]);
  assign busy_o      = (|lane_busy) | meta_busy;

endmodule

// File: source/fpslice_consts.svh
`ifndef FPSLICE_CONSTS_SVH
`define FPSLICE_CONSTS_SVH

// ------------------------------------------------------------
// Slice geometry
// ------------------------------------------------------------
`define FPS_WIDTH      32  // Datapath width of the slice
`define FPS_NUM_LANES  2   // SIMD lanes at the narrowest format

// ------------------------------------------------------------
// Format widths and canonical quiet NaNs
// ------------------------------------------------------------
`define FPS_FP32_W     32
`define FPS_FP16_W     16

// Sign clear, exponent all ones, only the quiet bit set
`define FPS_QNAN32     32'h7fc0_0000
`define FPS_QNAN16     16'h7e00

// ------------------------------------------------------------
// Side-band and pipeline
// ------------------------------------------------------------
`define FPS_TAG_W      4   // Tag carried beside each request
`define FPS_PIPE_REGS  2   // Register stages per lane

`endif

// File: source/fpslice_pkg.sv
`include "fpslice_consts.svh"

package fpslice_pkg;

  // ------------------------------------------------------------
  // Formats and operations
  // ------------------------------------------------------------
  typedef enum logic {
    FMT_FP32 = 1'b0,
    FMT_FP16 = 1'b1
  } fp_fmt_e;

  // Sign injection variants first, then min/max
  typedef enum logic [2:0] {
    OP_SGNJ  = 3'd0,
    OP_SGNJN = 3'd1,
    OP_SGNJX = 3'd2,
    OP_MIN   = 3'd3,
    OP_MAX   = 3'd4
  } op_e;

  // ------------------------------------------------------------
  // Status and transport structs
  // ------------------------------------------------------------
  // IEEE exception flags in RISC-V fflags order
  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } status_t;

  // One lane's result as it travels down its pipe
  typedef struct packed {
    logic [`FPS_WIDTH-1:0] word;    // Result in the low bits
    status_t               status;
    logic                  mask;    // SIMD mask bit for status collapse
  } lane_res_t;

  // Travels beside lane 0
  typedef struct packed {
    logic [`FPS_TAG_W-1:0] tag;
    fp_fmt_e               fmt;        // Destination format
    logic                  vectorial;  // Lane 1 holds a valid half
  } slice_meta_t;

endpackage

// File: source/lane_pipe.sv
`timescale 1ns/1ps
`include "fpslice_consts.svh"

module lane_pipe #(
  parameter type         payload_t = logic,
  parameter int unsigned NumRegs   = `FPS_PIPE_REGS
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  input  payload_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     valid_o,
  input  logic     ready_i,
  output logic     busy_o
);

  // Index i holds the item after i register stages
  payload_t data_q      [0:NumRegs];
  logic     valid_q     [0:NumRegs];
  logic     stage_ready [0:NumRegs];  // Ready travels backwards
  logic     alive_q;                  // Low while in reset and for its cycles

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      alive_q <= 1'b0;
    end else begin
      alive_q <= 1'b1;
    end
  end

  // Input side, nothing is taken before the pipe is alive
  assign data_q[0]  = data_i;
  assign valid_q[0] = valid_i & alive_q;

  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    logic load;

    // Advance if the next stage moves or only holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~valid_q[i+1];
    assign load           = stage_ready[i] & valid_q[i];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;  // Drop everything in flight
      end else if (stage_ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (load) begin
        data_q[i+1] <= data_q[i];
      end
    end
  end

  // Output side
  assign stage_ready[NumRegs] = ready_i;
  assign ready_o              = stage_ready[0] & alive_q;
  assign data_o               = data_q[NumRegs];
  assign valid_o              = valid_q[NumRegs];

  always_comb begin : busy_reduce
    busy_o = 1'b0;
    for (int i = 1; i <= NumRegs; i++) begin
      busy_o = busy_o | valid_q[i];
    end
  end

endmodule

// File: source/slice_lane_op.sv
`timescale 1ns/1ps
`include "fpslice_consts.svh"

module slice_lane_op #(
  parameter bit EnableFp32 = 1'b1
) (
  input  logic [`FPS_WIDTH-1:0]  op_a_i,
  input  logic [`FPS_WIDTH-1:0]  op_b_i,
  input  fpslice_pkg::op_e       op_i,
  input  fpslice_pkg::fp_fmt_e   fmt_i,
  input  logic                   scalar_i,
  input  logic                   mask_i,
  output fpslice_pkg::lane_res_t res_o
);

  localparam int unsigned MagW = `FPS_FP32_W - 1;       // Magnitude bits of FP32
  localparam int unsigned PadW = `FPS_WIDTH - `FPS_FP16_W;

  logic                  is_fp32;
  logic                  is_minmax;
  logic [`FPS_WIDTH-1:0] opa;
  logic [`FPS_WIDTH-1:0] opb;
  logic [`FPS_WIDTH-1:0] qnan;
  logic                  sign_a;
  logic                  sign_b;
  logic [MagW-1:0]       mag_a;
  logic [MagW-1:0]       mag_b;
  logic                  nan_a;
  logic                  nan_b;
  logic                  snan_a;
  logic                  snan_b;
  logic                  a_lt_b;
  logic                  inj_sign;
  logic [`FPS_WIDTH-1:0] sgnj_res;
  logic [`FPS_WIDTH-1:0] minmax_res;

  // A lane without FP32 support always works on halves
  assign is_fp32   = EnableFp32 && (fmt_i == fpslice_pkg::FMT_FP32);
  assign is_minmax = (op_i == fpslice_pkg::OP_MIN) || (op_i == fpslice_pkg::OP_MAX);

  // ------------------------------------------------------------
  // Operand preparation and NaN-box check
  // ------------------------------------------------------------
  always_comb begin : prepare_operands
    opa = op_a_i;
    opb = op_b_i;
    if (!is_fp32) begin
      opa = {{PadW{1'b0}}, op_a_i[`FPS_FP16_W-1:0]};
      opb = {{PadW{1'b0}}, op_b_i[`FPS_FP16_W-1:0]};
      // Scalar halves must sit under all ones
      if (scalar_i && !(&op_a_i[`FPS_WIDTH-1:`FPS_FP16_W])) begin
        opa = {{PadW{1'b0}}, `FPS_QNAN16};
      end
      if (scalar_i && !(&op_b_i[`FPS_WIDTH-1:`FPS_FP16_W])) begin
        opb = {{PadW{1'b0}}, `FPS_QNAN16};
      end
    end
  end

  always_comb begin : classify
    if (is_fp32) begin
      sign_a = opa[31];
      sign_b = opb[31];
      mag_a  = opa[30:0];
      mag_b  = opb[30:0];
      nan_a  = (&opa[30:23]) && (|opa[22:0]);
      nan_b  = (&opb[30:23]) && (|opb[22:0]);
      snan_a = nan_a && !opa[22];  // Quiet bit is the MSB of the mantissa
      snan_b = nan_b && !opb[22];
      qnan   = `FPS_QNAN32;
    end else begin
      sign_a = opa[15];
      sign_b = opb[15];
      mag_a  = {{(MagW-15){1'b0}}, opa[14:0]};
      mag_b  = {{(MagW-15){1'b0}}, opb[14:0]};
      nan_a  = (&opa[14:10]) && (|opa[9:0]);
      nan_b  = (&opb[14:10]) && (|opb[9:0]);
      snan_a = nan_a && !opa[9];
      snan_b = nan_b && !opb[9];
      qnan   = {{PadW{1'b0}}, `FPS_QNAN16};
    end
  end

  // Sign-magnitude ordering, so -0 sorts below +0
  always_comb begin : compare
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b;
    end else begin
      a_lt_b = mag_a < mag_b;
    end
  end

  // ------------------------------------------------------------
  // Result selection
  // ------------------------------------------------------------
  always_comb begin : sign_inject
    case (op_i)
      fpslice_pkg::OP_SGNJN: inj_sign = ~sign_b;
      fpslice_pkg::OP_SGNJX: inj_sign = sign_a ^ sign_b;
      default:               inj_sign = sign_b;
    endcase
    if (is_fp32) begin
      sgnj_res = {inj_sign, mag_a};
    end else begin
      sgnj_res = {{PadW{1'b0}}, inj_sign, mag_a[14:0]};
    end
  end

  always_comb begin : min_max
    if (nan_a && nan_b) begin
      minmax_res = qnan;
    end else if (nan_a) begin
      minmax_res = opb;  // Number wins over NaN
    end else if (nan_b) begin
      minmax_res = opa;
    end else if (op_i == fpslice_pkg::OP_MAX) begin
      minmax_res = a_lt_b ? opb : opa;
    end else begin
      minmax_res = a_lt_b ? opa : opb;
    end
  end

  always_comb begin : drive_result
    res_o           = '0;
    res_o.word      = is_minmax ? minmax_res : sgnj_res;
    res_o.status.nv = is_minmax && (snan_a || snan_b);  // Sign injection never flags
    res_o.mask      = mask_i;
  end

endmodule

// File: source/slice_result_pack.sv
`timescale 1ns/1ps
`include "fpslice_consts.svh"

module slice_result_pack (
  input  fpslice_pkg::lane_res_t   lane0_i,
  input  fpslice_pkg::lane_res_t   lane1_i,
  input  fpslice_pkg::slice_meta_t meta_i,
  output logic [`FPS_WIDTH-1:0]    result_o,
  output fpslice_pkg::status_t     status_o
);

  localparam int unsigned HalfW = `FPS_FP16_W;

  fpslice_pkg::lane_res_t    lanes [`FPS_NUM_LANES];
  logic [`FPS_NUM_LANES-1:0] lane_active;  // Lanes that carry part of this result
  logic [HalfW-1:0]          lo_half;
  logic [HalfW-1:0]          hi_half;

  assign lanes[0] = lane0_i;
  assign lanes[1] = lane1_i;

  // Lane 1 only takes part in vectorial operations
  assign lane_active = {meta_i.vectorial, 1'b1};

  // ------------------------------------------------------------
  // Result packing by format
  // ------------------------------------------------------------
  assign lo_half = lane0_i.word[HalfW-1:0];

  always_comb begin : upper_half
    if (meta_i.vectorial) begin
      hi_half = lane1_i.word[HalfW-1:0];
    end else begin
      hi_half = '1;  // NaN-box of a scalar half
    end
  end

  always_comb begin : pack_result
    if (meta_i.fmt == fpslice_pkg::FMT_FP32) begin
      result_o = lane0_i.word;
    end else begin
      result_o = {hi_half, lo_half};
    end
  end

  // ------------------------------------------------------------
  // Status collapse
  // ------------------------------------------------------------
  always_comb begin : collapse_status
    fpslice_pkg::status_t acc;
    acc = '0;
    for (int i = 0; i < `FPS_NUM_LANES; i++) begin
      // Masked-off lanes keep their flags to themselves
      if (lane_active[i] && lanes[i].mask) begin
        acc = acc | lanes[i].status;
      end
    end
    status_o = acc;
  end

endmodule

// File: src.f
+incdir+source
source/fpslice_pkg.sv
source/lane_pipe.sv
source/slice_lane_op.sv
source/slice_result_pack.sv
source/fp_multifmt_slice.sv
dv/tb_fp_multifmt_slice.sv
